/* gvp_core.f */
design/gvp_cfg_pkg.sv
design/gvp_vec_pkg.sv
design/gvp_config_decode.sv
design/gvp_sequencer.sv
design/gvp_output_stage.sv
design/gvp_core.sv
sim/gvp_core_chk.sv
sim/gvp_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the gvp_core testbench, exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f gvp_core.f \
    --top-module gvp_core_tb -o gvp_core_sim \
    && ./obj_dir/gvp_core_sim \
    || { echo "gvp_core simulation did not pass"; exit 1; }
exit 0

/* sim/gvp_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module gvp_core_tb
    import gvp_cfg_pkg::*;
    import gvp_vec_pkg::*;
();

    localparam int NUM_CASES = 4;
    localparam int MAX_VEC   = 4;     // vectors per test program
    localparam int MAX_REC   = 64;    // model walk limit
    localparam int TIMEOUT   = 1000;  // cycles per wait

    typedef struct packed {
        logic [1:0]  store;
        logic [31:0] options;
        logic [31:0] index;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] z;
        logic [31:0] u;
    } sample_rec_t;

    logic        a_clk;
    logic        reset_flg;
    logic        config_valid;
    logic [31:0] config_addr;
    cfg_word_u   config_data;
    logic        sample_ready;
    logic        sample_valid;
    logic [31:0] sample_x;
    logic [31:0] sample_y;
    logic [31:0] sample_z;
    logic [31:0] sample_u;
    logic [31:0] sample_options;
    logic [31:0] sample_index;
    logic [1:0]  sample_store;
    logic        gvp_finished;
    logic        gvp_hold;

    // program table, one row per case
    vec_record_t prog_tab   [NUM_CASES][MAX_VEC];
    int          prog_len   [NUM_CASES];
    logic [31:0] preset_tab [NUM_CASES];
    logic [31:0] ropt_tab   [NUM_CASES];
    bit          pause_tab  [NUM_CASES];

    sample_rec_t exp_q[$];           // expected records of the running case
    longint      mx, my, mz, mu;     // model accumulators, never clamped

    gvp_core #(
        .NUM_VECTORS_N2 (4)
    ) u_gvp_core (
        .a_clk          (a_clk),
        .reset_flg      (reset_flg),
        .config_valid   (config_valid),
        .config_addr    (config_addr),
        .config_data    (config_data),
        .sample_valid   (sample_valid),
        .sample_ready   (sample_ready),
        .sample_x       (sample_x),
        .sample_y       (sample_y),
        .sample_z       (sample_z),
        .sample_u       (sample_u),
        .sample_options (sample_options),
        .sample_index   (sample_index),
        .sample_store   (sample_store),
        .gvp_finished   (gvp_finished),
        .gvp_hold       (gvp_hold)
    );

    bind gvp_core gvp_core_chk u_chk (
        .a_clk          (a_clk),
        .reset_flg      (reset_flg),
        .sample_valid   (sample_valid),
        .sample_ready   (sample_ready),
        .sample_x       (sample_x),
        .sample_y       (sample_y),
        .sample_z       (sample_z),
        .sample_u       (sample_u),
        .sample_options (sample_options),
        .sample_index   (sample_index),
        .sample_store   (sample_store)
    );

    initial
    begin
        a_clk = 1'b0;
        forever #10 a_clk = ~a_clk;  // 20 ns period
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic tick();
        @(posedge a_clk);
        #2;  // inputs move just after the edge
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp)
        else report_failure($sformatf("Error: %s got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    task automatic check_quiet();
        assert (sample_valid === 1'b0)
        else report_failure("sample_valid rose while the core was parked");
        assert (gvp_finished === 1'b0)
        else report_failure("gvp_finished high before the program ran");
    endtask

    task automatic settle(input int n);
        repeat (n)
        begin
            tick();
            check_quiet();
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (gvp_finished || sample_valid)
        begin
            tick();
            cycles++;
            assert (cycles < TIMEOUT)
            else report_failure("timed out waiting for the core to go idle");
        end
    endtask

    task automatic write_cfg(input logic [31:0] addr, input cfg_word_u data);
        config_valid = 1'b1;  // one-cycle write, no ready
        config_addr  = addr;
        config_data  = data;
        tick();
        config_valid = 1'b0;
    endtask

    function automatic cfg_word_u low_word(input logic [31:0] v);
        cfg_word_u w;
        w        = '0;
        w[31:0]  = v;
        return w;
    endfunction

    function automatic vec_record_t make_vector(input int n, input int iin,
        input logic [31:0] opts, input int nrep, input int next,
        input int dx, input int dy, input int dz, input int du);
        vec_record_t r;
        r         = '0;
        r.n       = n;
        r.iin     = iin;
        r.options = opts;
        r.nrep    = nrep;
        r.next    = next;
        r.dx      = dx;
        r.dy      = dy;
        r.dz      = dz;
        r.du      = du;
        return r;
    endfunction

    task automatic fill_table();
        // single vector, plain header/data/end order
        prog_tab[0][0] = make_vector(3, 1, 32'h11, 0, 0, 5, -2, 1, 3);
        prog_tab[0][1] = make_vector(0, 0, 32'h0, 0, 0, 0, 0, 0, 0);
        prog_len[0]    = 2;
        preset_tab[0]  = 32'd100;
        ropt_tab[0]    = 32'ha5;
        pause_tab[0]   = 1'b0;
        // vector 1 loops back to vector 0 twice
        prog_tab[1][0] = make_vector(2, 0, 32'h21, 0, 0, 1, 1, 0, -1);
        prog_tab[1][1] = make_vector(1, 2, 32'h22, 2, -1, -3, 2, 4, 2);
        prog_tab[1][2] = make_vector(0, 0, 32'h0, 0, 0, 0, 0, 0, 0);
        prog_len[1]    = 3;
        preset_tab[1]  = 32'h40;
        ropt_tab[1]    = 32'hc3;
        pause_tab[1]   = 1'b0;
        // big steps, x and u clamp high, y clamps low
        prog_tab[2][0] = make_vector(4, 0, 32'h31, 1, 0, 32'h2000_0000, -32'sh2000_0000, 7, 3);
        prog_tab[2][1] = make_vector(0, 0, 32'h0, 0, 0, 0, 0, 0, 0);
        prog_len[2]    = 2;
        preset_tab[2]  = 32'h7fff_fff0;
        ropt_tab[2]    = 32'h5a;
        pause_tab[2]   = 1'b0;
        // x swings back through zero into the low clamp, run starts paused
        prog_tab[3][0] = make_vector(5, 3, 32'h41, 0, 0, -32'sh2000_0000, 32'h1000_0000, -1, -5);
        prog_tab[3][1] = make_vector(0, 0, 32'h0, 0, 0, 0, 0, 0, 0);
        prog_len[3]    = 2;
        preset_tab[3]  = 32'hffff_ff00;
        ropt_tab[3]    = 32'h3c;
        pause_tab[3]   = 1'b1;
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic logic [31:0] expected_sat(input longint v);
        if (v > 64'sd2147483647)
            return 32'h7fff_ffff;
        else if (v < -64'sd2147483647)
            return 32'h8000_0001;  // symmetric low limit
        return v[31:0];
    endfunction

    task automatic add_expected(input logic [1:0] store, input logic [31:0] opts,
                                input logic [31:0] idx);
        sample_rec_t r;
        r.store   = store;
        r.options = opts;
        r.index   = idx;
        r.x       = expected_sat(mx);
        r.y       = expected_sat(my);
        r.z       = expected_sat(mz);
        r.u       = expected_sat(mu);
        exp_q.push_back(r);
    endtask

    task automatic build_expected(input int c);
        vec_record_t v;
        logic [31:0] rep_cnt [MAX_VEC];
        logic [31:0] i;
        logic [31:0] ii;
        int          pc;
        int          guard;
        bit          done;
        bit          sec_end;
        exp_q.delete();
        mu = longint'(signed'(preset_tab[c]));  // x, y, z carry over
        for (int k = 0; k < MAX_VEC; k++)
        begin
            rep_cnt[k] = prog_tab[c][k].nrep;
        end
        pc    = 0;
        guard = 0;
        done  = 1'b0;
        while (!done)
        begin
            v = prog_tab[c][pc];
            if (v.n == 0)
            begin
                add_expected(STORE_END, END_OPTIONS, 32'd0);
                done = 1'b1;
            end
            else
            begin
                add_expected(STORE_HEADER, v.options, v.n);
                i       = v.n;
                ii      = v.iin;
                sec_end = 1'b0;
                while (!sec_end)
                begin
                    mx += longint'(signed'(v.dx));  // every step adds
                    my += longint'(signed'(v.dy));
                    mz += longint'(signed'(v.dz));
                    mu += longint'(signed'(v.du));
                    if (ii != 0)
                        ii--;
                    else if (i != 0)
                    begin
                        add_expected(STORE_DATA, v.options, i);
                        i--;
                        ii = v.iin;
                    end
                    else
                        sec_end = 1'b1;
                end
                if (rep_cnt[pc] != 0)
                begin
                    rep_cnt[pc]--;
                    pc += int'(signed'(v.next));  // loop jump
                end
                else
                begin
                    rep_cnt[pc] = v.nrep;
                    pc++;
                end
            end
            guard++;
            assert (guard < MAX_REC && pc >= 0 && pc < MAX_VEC)
            else report_failure("program table walks outside its vectors");
        end
    endtask

    //////////////////////////////
    // case runner
    //////////////////////////////

    task automatic collect_records();
        sample_rec_t e;
        int          got;
        int          cycles;
        bit          seen_end;
        got      = 0;
        cycles   = 0;
        seen_end = 1'b0;
        while (!seen_end)
        begin
            sample_ready = ($urandom_range(3) != 0);  // ready about 3 in 4
            if (sample_valid && sample_ready)
            begin
                assert (got < exp_q.size())
                else report_failure("more sample records than the model expects");
                e = exp_q[got];
                compare_field("sample_store", 32'(sample_store), 32'(e.store));
                compare_field("sample_options", sample_options, e.options);
                compare_field("sample_index", sample_index, e.index);
                compare_field("sample_x", sample_x, e.x);
                compare_field("sample_y", sample_y, e.y);
                compare_field("sample_z", sample_z, e.z);
                compare_field("sample_u", sample_u, e.u);
                if (sample_store == STORE_END)
                begin
                    assert (gvp_finished === 1'b1)
                    else report_failure("gvp_finished low on the end record");
                    seen_end = 1'b1;
                end
                got++;
            end
            tick();
            cycles++;
            assert (cycles < TIMEOUT)
            else report_failure("timed out waiting for the end record");
        end
        sample_ready = 1'b1;
        assert (got == exp_q.size())
        else report_failure("fewer sample records than the model expects");
    endtask

    task automatic run_case(input int c);
        vec_record_t rec;
        cfg_word_u   w;
        write_cfg(CTRL_ADDR, low_word(32'd1));  // park sequencer
        wait_idle();
        write_cfg(RESET_OPT_ADDR, low_word(ropt_tab[c]));
        check_quiet();
        for (int k = 0; k < prog_len[c]; k++)
        begin
            rec          = prog_tab[c][k];
            rec.vec_addr = k;
            w            = '0;
            w.rec        = rec;
            write_cfg(VEC_PROG_ADDR, w);
            check_quiet();
        end
        w                = '0;
        w.preset.u_preset = preset_tab[c];
        write_cfg(VEC_PRESET_ADDR, w);
        settle(4);  // memory and repeat counters loaded
        build_expected(c);
        if (pause_tab[c])
        begin
            write_cfg(CTRL_ADDR, low_word(32'd2));  // released but paused
            settle(6);
            assert (gvp_hold === 1'b1)
            else report_failure("gvp_hold low while the run was paused");
        end
        write_cfg(CTRL_ADDR, low_word(32'd0));
        collect_records();
    endtask

    initial
    begin
        void'($urandom(32'h0222_2ab6));
        reset_flg    = 1'b1;
        config_valid = 1'b0;
        config_addr  = '0;
        config_data  = '0;
        sample_ready = 1'b1;
        mx           = 0;
        my           = 0;
        mz           = 0;
        mu           = 0;
        fill_table();
        repeat (2) @(posedge a_clk);
        #2;
        reset_flg = 1'b0;
        check_quiet();
        for (int c = 0; c < NUM_CASES; c++)
        begin
            run_case(c);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/gvp_core_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module gvp_core_chk
    import gvp_vec_pkg::*;
(
    input wire        a_clk,
    input wire        reset_flg,
    input wire        sample_valid,
    input wire        sample_ready,
    input wire [31:0] sample_x,
    input wire [31:0] sample_y,
    input wire [31:0] sample_z,
    input wire [31:0] sample_u,
    input wire [31:0] sample_options,
    input wire [31:0] sample_index,
    input wire [1:0]  sample_store
);

    logic [193:0] payload;  // whole record, one vector

    assign payload = {sample_x, sample_y, sample_z, sample_u,
                      sample_options, sample_index, sample_store};

    //////////////////////////////
    // sample stream rules
    //////////////////////////////

    reset_quiet: assert property (@(posedge a_clk) reset_flg |=> !sample_valid)
        else $error("sample_valid high right after a reset cycle");

    // stalled record must not move
    hold_stable: assert property (@(posedge a_clk) disable iff (reset_flg)
        sample_valid && !sample_ready |=> sample_valid && $stable(payload))
        else $error("sample record changed or dropped while stalled");

    no_silent: assert property (@(posedge a_clk) disable iff (reset_flg)
        sample_valid |-> sample_store != STORE_NONE)  // silent steps never surface
        else $error("valid sample carries the no-store code");

endmodule

`default_nettype wire

/* design/gvp_core.sv */
`timescale 1ns/1ps
`default_nettype none

module gvp_core
    import gvp_cfg_pkg::*;
    import gvp_vec_pkg::*;
#(
    parameter int NUM_VECTORS_N2 = 4  // log2 program depth
)
(
    input  wire         a_clk,
    input  wire         reset_flg,
    input  wire         config_valid,
    input  wire [31:0]  config_addr,
    input  wire cfg_word_u config_data,
    output wire         sample_valid,
    input  wire         sample_ready,
    output wire [31:0]  sample_x,
    output wire [31:0]  sample_y,
    output wire [31:0]  sample_z,
    output wire [31:0]  sample_u,
    output wire [31:0]  sample_options,
    output wire [31:0]  sample_index,
    output wire [1:0]   sample_store,
    output wire         gvp_finished,
    output wire         gvp_hold
);

    //////////////////////////////
    // decode to sequencer
    //////////////////////////////

    logic                      run_reset;
    logic                      run_pause;
    logic [31:0]               reset_options;
    logic                      prog_we;
    logic [NUM_VECTORS_N2-1:0] prog_addr;
    vec_record_t               prog_rec;
    logic                      preset_we;
    logic [31:0]               u_preset;

    // sequencer to output stage
    logic                      step_valid;
    logic                      step_ready;
    logic signed [ACC_W-1:0]   acc_x;
    logic signed [ACC_W-1:0]   acc_y;
    logic signed [ACC_W-1:0]   acc_z;
    logic signed [ACC_W-1:0]   acc_u;
    logic [31:0]               step_options;
    logic [31:0]               step_index;
    logic [1:0]                step_store;

    gvp_config_decode #(
        .NUM_VECTORS_N2 (NUM_VECTORS_N2)
    ) u_config_decode (
        .a_clk         (a_clk),
        .reset_flg     (reset_flg),
        .config_valid  (config_valid),
        .config_addr   (config_addr),
        .config_data   (config_data),
        .run_reset     (run_reset),
        .run_pause     (run_pause),
        .reset_options (reset_options),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_rec      (prog_rec),
        .preset_we     (preset_we),
        .u_preset      (u_preset)
    );

    gvp_sequencer #(
        .NUM_VECTORS_N2 (NUM_VECTORS_N2)
    ) u_sequencer (
        .a_clk         (a_clk),
        .reset_flg     (reset_flg),
        .run_reset     (run_reset),
        .run_pause     (run_pause),
        .reset_options (reset_options),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_rec      (prog_rec),
        .preset_we     (preset_we),
        .u_preset      (u_preset),
        .step_ready    (step_ready),
        .step_valid    (step_valid),
        .acc_x         (acc_x),
        .acc_y         (acc_y),
        .acc_z         (acc_z),
        .acc_u         (acc_u),
        .step_options  (step_options),
        .step_index    (step_index),
        .step_store    (step_store),
        .gvp_finished  (gvp_finished),
        .gvp_hold      (gvp_hold)
    );

    gvp_output_stage u_output_stage (
        .a_clk          (a_clk),
        .reset_flg      (reset_flg),
        .step_valid     (step_valid),
        .acc_x          (acc_x),
        .acc_y          (acc_y),
        .acc_z          (acc_z),
        .acc_u          (acc_u),
        .step_options   (step_options),
        .step_index     (step_index),
        .step_store     (step_store),
        .sample_ready   (sample_ready),
        .step_ready     (step_ready),
        .sample_valid   (sample_valid),
        .sample_x       (sample_x),
        .sample_y       (sample_y),
        .sample_z       (sample_z),
        .sample_u       (sample_u),
        .sample_options (sample_options),
        .sample_index   (sample_index),
        .sample_store   (sample_store)
    );

endmodule

`default_nettype wire

/* design/gvp_output_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module gvp_output_stage
    import gvp_vec_pkg::*;
(
    input  wire                     a_clk,
    input  wire                     reset_flg,
    input  wire                     step_valid,
    input  wire signed [ACC_W-1:0]  acc_x,
    input  wire signed [ACC_W-1:0]  acc_y,
    input  wire signed [ACC_W-1:0]  acc_z,
    input  wire signed [ACC_W-1:0]  acc_u,
    input  wire [31:0]              step_options,
    input  wire [31:0]              step_index,
    input  wire [1:0]               step_store,
    input  wire                     sample_ready,
    output logic                    step_ready,
    output logic                    sample_valid,
    output logic [31:0]             sample_x,
    output logic [31:0]             sample_y,
    output logic [31:0]             sample_z,
    output logic [31:0]             sample_u,
    output logic [31:0]             sample_options,
    output logic [31:0]             sample_index,
    output logic [1:0]              sample_store
);

    logic take;  // step carries a record and the slot is free

    // clamp to the symmetric 32-bit range
    function automatic logic [31:0] sat32(input logic signed [ACC_W-1:0] v);
        if (v > SAT_MAX)
            return SAT_MAX[31:0];
        else if (v < SAT_MIN)
            return SAT_MIN[31:0];
        return v[31:0];
    endfunction

    assign step_ready = ~sample_valid | sample_ready;  // empty or draining
    assign take       = step_valid & step_ready & (step_store != STORE_NONE);

    //////////////////////////////
    // one-record holding register
    //////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
            sample_valid <= 1'b0;
        else if (step_valid && step_ready)
            sample_valid <= (step_store != STORE_NONE);  // silent steps just drain
        else if (sample_ready)
            sample_valid <= 1'b0;
    end

    always_ff @(posedge a_clk)
    begin
        if (take)
        begin
            sample_x       <= sat32(acc_x);
            sample_y       <= sat32(acc_y);
            sample_z       <= sat32(acc_z);
            sample_u       <= sat32(acc_u);
            sample_options <= step_options;
            sample_index   <= step_index;
            sample_store   <= step_store;
        end
    end

endmodule

`default_nettype wire

/* design/gvp_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module gvp_sequencer
    import gvp_cfg_pkg::*;
    import gvp_vec_pkg::*;
#(
    parameter int NUM_VECTORS_N2 = 4
)
(
    input  wire                       a_clk,
    input  wire                       reset_flg,
    input  wire                       run_reset,
    input  wire                       run_pause,
    input  wire [31:0]                reset_options,
    input  wire                       prog_we,
    input  wire [NUM_VECTORS_N2-1:0]  prog_addr,
    input  wire vec_record_t          prog_rec,
    input  wire                       preset_we,
    input  wire [31:0]                u_preset,
    input  wire                       step_ready,
    output logic                      step_valid,
    output logic signed [ACC_W-1:0]   acc_x,
    output logic signed [ACC_W-1:0]   acc_y,
    output logic signed [ACC_W-1:0]   acc_z,
    output logic signed [ACC_W-1:0]   acc_u,
    output logic [31:0]               step_options,
    output logic [31:0]               step_index,
    output logic [1:0]                step_store,
    output logic                      gvp_finished,
    output logic                      gvp_hold
);

    localparam int NUM_VECTORS = 1 << NUM_VECTORS_N2;
    localparam logic signed [NUM_VECTORS_N2:0] PC_ONE = 1;

    //////////////////////////////
    // vector program memory
    //////////////////////////////

    logic [31:0]                    vec_n       [NUM_VECTORS];
    logic [31:0]                    vec_iin     [NUM_VECTORS];
    logic [31:0]                    vec_options [NUM_VECTORS];
    logic [31:0]                    vec_nrep    [NUM_VECTORS];
    logic signed [NUM_VECTORS_N2:0] vec_next    [NUM_VECTORS];  // +/- program depth
    logic signed [31:0]             vec_dx      [NUM_VECTORS];
    logic signed [31:0]             vec_dy      [NUM_VECTORS];
    logic signed [31:0]             vec_dz      [NUM_VECTORS];
    logic signed [31:0]             vec_du      [NUM_VECTORS];

    // live loop counters, reloaded from nrep
    logic [31:0]                    vec_i       [NUM_VECTORS];

    // program state
    logic signed [NUM_VECTORS_N2:0] pvc;        // program counter plus sign bit
    logic [NUM_VECTORS_N2-1:0]      pv;         // memory index
    logic [31:0]                    i;          // points left
    logic [31:0]                    ii;         // intermediate steps left
    logic                           load_next;
    logic                           adv;        // step slot free this cycle

    assign pv  = pvc[NUM_VECTORS_N2-1:0];
    assign adv = ~step_valid | step_ready;

    always_ff @(posedge a_clk)
    begin
        if (prog_we)
        begin
            vec_n[prog_addr]       <= prog_rec.n;
            vec_iin[prog_addr]     <= prog_rec.iin;
            vec_options[prog_addr] <= prog_rec.options;
            vec_nrep[prog_addr]    <= prog_rec.nrep;
            vec_next[prog_addr]    <= prog_rec.next[NUM_VECTORS_N2:0];  // low bits only
            vec_dx[prog_addr]      <= prog_rec.dx;
            vec_dy[prog_addr]      <= prog_rec.dy;
            vec_dz[prog_addr]      <= prog_rec.dz;
            vec_du[prog_addr]      <= prog_rec.du;
        end
    end

    //////////////////////////////
    // step engine
    //////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
        begin
            pvc          <= '0;
            i            <= '0;
            ii           <= '0;
            load_next    <= 1'b1;
            gvp_finished <= 1'b0;
            gvp_hold     <= 1'b0;
            step_valid   <= 1'b0;
            step_options <= '0;
            step_index   <= '0;
            step_store   <= STORE_NONE;
            acc_x        <= '0;
            acc_y        <= '0;
            acc_z        <= '0;
            acc_u        <= '0;
            for (int k = 0; k < NUM_VECTORS; k++)
            begin
                vec_i[k] <= '0;
            end
        end
        else
        begin
            gvp_hold <= run_pause & ~run_reset & ~gvp_finished;
            if (adv)  // nothing moves while the output stage refuses
            begin
                if (run_reset)
                begin
                    pvc          <= '0;
                    gvp_finished <= 1'b0;
                    load_next    <= 1'b1;
                    step_valid   <= 1'b0;
                    step_store   <= STORE_NONE;
                    step_options <= reset_options;  // idle options
                    for (int k = 0; k < NUM_VECTORS; k++)
                    begin
                        vec_i[k] <= vec_nrep[k];
                    end
                end
                else if (gvp_finished || run_pause)
                begin
                    step_valid <= 1'b0;  // parked, counters held
                    if (gvp_finished)
                        step_options <= reset_options;
                end
                else if (load_next)
                begin
                    // section start or program end
                    load_next  <= 1'b0;
                    step_valid <= 1'b1;
                    step_index <= vec_n[pv];
                    if (vec_n[pv] == 0)
                    begin
                        gvp_finished <= 1'b1;
                        step_store   <= STORE_END;
                        step_options <= END_OPTIONS;
                    end
                    else
                    begin
                        i            <= vec_n[pv];
                        ii           <= vec_iin[pv];
                        step_store   <= STORE_HEADER;
                        step_options <= vec_options[pv];
                    end
                end
                else
                begin
                    // every step adds the increments
                    step_valid <= 1'b1;
                    acc_x      <= acc_x + vec_dx[pv];
                    acc_y      <= acc_y + vec_dy[pv];
                    acc_z      <= acc_z + vec_dz[pv];
                    acc_u      <= acc_u + vec_du[pv];
                    if (ii != 0)
                    begin
                        ii         <= ii - 1;  // intermediate, no record
                        step_store <= STORE_NONE;
                    end
                    else if (i != 0)
                    begin
                        step_store <= STORE_DATA;
                        step_index <= i;
                        i          <= i - 1;
                        ii         <= vec_iin[pv];
                    end
                    else
                    begin
                        // section end, pick next vector
                        step_store <= STORE_NONE;
                        load_next  <= 1'b1;
                        if (vec_i[pv] != 0)
                        begin
                            vec_i[pv] <= vec_i[pv] - 1;
                            pvc       <= pvc + vec_next[pv];  // back to loop head
                        end
                        else
                        begin
                            vec_i[pv] <= vec_nrep[pv];        // rearm for next pass
                            pvc       <= pvc + PC_ONE;
                        end
                    end
                end
            end
            // preset wins over a same-cycle add
            if (preset_we)
                acc_u <= {{VEC_OV_BITS{u_preset[31]}}, u_preset};
        end
    end

endmodule

`default_nettype wire

/* design/gvp_config_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module gvp_config_decode
    import gvp_cfg_pkg::*;
#(
    parameter int NUM_VECTORS_N2 = 4
)
(
    input  wire                      a_clk,
    input  wire                      reset_flg,
    input  wire                      config_valid,
    input  wire [31:0]               config_addr,
    input  wire cfg_word_u           config_data,
    output logic                     run_reset,
    output logic                     run_pause,
    output logic [31:0]              reset_options,
    output logic                     prog_we,
    output logic [NUM_VECTORS_N2-1:0] prog_addr,
    output vec_record_t              prog_rec,
    output logic                     preset_we,
    output logic [31:0]              u_preset
);

    // input capture stage
    logic        cfg_valid_q;
    logic [31:0] cfg_addr_q;
    cfg_word_u   cfg_data_q;

    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
            cfg_valid_q <= 1'b0;
        else
            cfg_valid_q <= config_valid;
    end

    always_ff @(posedge a_clk)
    begin
        cfg_addr_q <= config_addr;  // qualified by cfg_valid_q
        cfg_data_q <= config_data;
    end

    //////////////////////////////
    // address decode
    //////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
        begin
            run_reset     <= 1'b1;  // core parked until host releases it
            run_pause     <= 1'b0;
            reset_options <= '0;
            prog_we       <= 1'b0;
            preset_we     <= 1'b0;
        end
        else
        begin
            // strobes high for one cycle per write
            prog_we   <= cfg_valid_q && (cfg_addr_q == VEC_PROG_ADDR);
            preset_we <= cfg_valid_q && (cfg_addr_q == VEC_PRESET_ADDR);
            if (cfg_valid_q && (cfg_addr_q == CTRL_ADDR))
            begin
                run_reset <= cfg_data_q[0];
                run_pause <= cfg_data_q[1];
            end
            if (cfg_valid_q && (cfg_addr_q == RESET_OPT_ADDR))
                reset_options <= cfg_data_q[31:0];
        end
    end

    // payload that travels with the strobes
    always_ff @(posedge a_clk)
    begin
        prog_addr <= cfg_data_q.rec.vec_addr[NUM_VECTORS_N2-1:0];  // program view
        prog_rec  <= cfg_data_q.rec;
        u_preset  <= cfg_data_q.preset.u_preset;                 // preset view
    end

endmodule

`default_nettype wire

/* design/gvp_vec_pkg.sv */
`default_nettype none

package gvp_vec_pkg;

    //////////////////////////////
    // accumulator arithmetic
    //////////////////////////////

    localparam int VEC_OV_BITS = 2;                      // headroom above 32 bits
    localparam int ACC_W       = 32 + VEC_OV_BITS;      // no saturation inside the loop

    // clamp limits, symmetric
    localparam logic signed [ACC_W-1:0] SAT_MAX = 34'sd2147483647;
    localparam logic signed [ACC_W-1:0] SAT_MIN = -34'sd2147483647;

    //////////////////////////////
    // store codes
    //////////////////////////////

    localparam logic [1:0] STORE_NONE   = 2'd0;          // step without a record
    localparam logic [1:0] STORE_DATA   = 2'd1;          // data point
    localparam logic [1:0] STORE_HEADER = 2'd2;          // section start
    localparam logic [1:0] STORE_END    = 2'd3;          // program done

    localparam logic [31:0] END_OPTIONS = 32'hffff_ffff; // options on the end record

endpackage

`default_nettype wire

/* design/gvp_cfg_pkg.sv */
`default_nettype none

package gvp_cfg_pkg;

    //////////////////////////////
    // configuration bus layout
    //////////////////////////////

    localparam int CFG_WORDS = 10;                       // 32-bit words, 320-bit bus

    localparam logic [31:0] CTRL_ADDR       = 32'd1;     // bit 0 reset, bit 1 pause
    localparam logic [31:0] RESET_OPT_ADDR  = 32'd2;     // options shown while idle
    localparam logic [31:0] VEC_PROG_ADDR   = 32'd3;     // one vector record
    localparam logic [31:0] VEC_PRESET_ADDR = 32'd4;     // preset block

    // programming view, word 0 sits in the low bits
    typedef struct packed {
        logic [31:0] du;                                 // bias increment
        logic [31:0] dz;
        logic [31:0] dy;
        logic [31:0] dx;                                 // word 6
        logic [31:0] next;                               // signed loop jump
        logic [31:0] nrep;                               // extra section passes
        logic [31:0] options;
        logic [31:0] iin;                                // intermediate steps per point
        logic [31:0] n;                                  // points, zero ends program
        logic [31:0] vec_addr;                           // word 0
    } vec_record_t;

    // preset view, only u is taken from it
    typedef struct packed {
        logic [CFG_WORDS-5:0][31:0] unused_hi;          // words 4..9
        logic [31:0]                u_preset;           // word 3
        logic [2:0][31:0]           unused_lo;          // words 0..2
    } preset_block_t;

    // same 320 bits, decoded by address
    typedef union packed {
        vec_record_t   rec;
        preset_block_t preset;
    } cfg_word_u;

endpackage

`default_nettype wire
